/* all.f */
source/fetch_pkg.sv
source/fetch_stage.sv
source/icache_way.sv
source/icache_ctrl.sv
source/fetch_top.sv
verification/mem_model.sv
verification/fetch_tb.sv

/* run.sh */
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module fetch_tb \
    -f all.f \
    --Mdir obj_dir \
    -o fetch_sim

./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi

if ! grep -q "No errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"

/* verification/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    // rough cycles per test, refills dominate
    localparam int TEST_CYCLES  = 400 + 900 + 400 + 200 + 300 + 600;
    localparam int MARGIN       = 4;

    localparam addr_t BOOT_PC   = 32'hbfc0_0000;
    // three lines sharing index 0x80
    localparam addr_t LINE_A    = 32'h0001_0800;
    localparam addr_t LINE_B    = 32'h0002_0800;
    localparam addr_t LINE_C    = 32'h0003_0800;
    localparam addr_t BR_TARGET = 32'h0006_0000;
    localparam addr_t STALL_TGT = 32'h0007_0000;
    localparam addr_t MIS_TGT   = 32'h0004_0102;
    localparam addr_t EPC_ADDR  = 32'h0005_0200;
    // last word of an unfetched line, the word after it misses
    localparam addr_t LINE_END  = 32'h0008_000c;

    logic      clk;
    logic      reset;
    logic      decode_allowin;
    logic      br_taken;
    logic      br_stall;
    addr_t     br_target;
    logic      br_delay_slot;
    logic      flush;
    logic      eret;
    addr_t     epc;
    logic      mfc0_stall;
    logic      fs_valid;
    addr_t     fs_pc;
    inst_t     fs_inst;
    logic      fs_ex;
    exc_code_t fs_exc_code;
    logic      fs_bd;
    logic      mem_req;
    addr_t     mem_addr;
    logic      mem_ack;
    line_t     mem_line;
    int        refill_count;

    // words seen by decode, in order
    addr_t     q_pc[$];
    inst_t     q_inst[$];
    logic      q_ex[$];
    exc_code_t q_code[$];
    logic      q_bd[$];
    addr_t     refill_log[$];
    logic      mem_req_prev;
    logic      bp_en;
    int        error_count;
    int        check_count;

    fetch_top fetch_top_inst (
        .clk            (clk),
        .reset          (reset),
        .decode_allowin (decode_allowin),
        .br_taken       (br_taken),
        .br_stall       (br_stall),
        .br_target      (br_target),
        .br_delay_slot  (br_delay_slot),
        .flush          (flush),
        .eret           (eret),
        .epc            (epc),
        .mfc0_stall     (mfc0_stall),
        .fs_valid       (fs_valid),
        .fs_pc          (fs_pc),
        .fs_inst        (fs_inst),
        .fs_ex          (fs_ex),
        .fs_exc_code    (fs_exc_code),
        .fs_bd          (fs_bd),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_ack        (mem_ack),
        .mem_line       (mem_line)
    );

    mem_model mem_model_inst (
        .clk          (clk),
        .reset        (reset),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_ack      (mem_ack),
        .mem_line     (mem_line),
        .refill_count (refill_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // mid cycle sample, transfer happens at the next rising edge
    // a word handed over while decode is flushed does not count
    always @(negedge clk) begin
        if (!reset && fs_valid && decode_allowin && !flush && !eret) begin
            q_pc.push_back(fs_pc);
            q_inst.push_back(fs_inst);
            q_ex.push_back(fs_ex);
            q_code.push_back(fs_exc_code);
            q_bd.push_back(fs_bd);
        end
        if (mem_req && !mem_req_prev) begin
            refill_log.push_back(mem_addr);
        end
        mem_req_prev = mem_req;
    end

    // random decode stalls
    always @(posedge clk) begin
        if (bp_en) begin
            decode_allowin <= ($urandom % 4) != 0;
        end
    end

    function automatic inst_t mem_word(input addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    function automatic int refills_of(input addr_t line_addr);
        int n = 0;
        foreach (refill_log[i]) begin
            if (refill_log[i] == line_addr) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic check(input logic ok, input string msg);
        check_count++;
        assert (ok) else begin
            error_count++;
            $display("ERR %0t: %s", $time, msg);
        end
    endtask

    task automatic clear_words();
        q_pc.delete();
        q_inst.delete();
        q_ex.delete();
        q_code.delete();
        q_bd.delete();
    endtask

    task automatic next_word(output addr_t pc, output inst_t inst, output logic ex,
                             output exc_code_t code, output logic bd);
        while (q_pc.size() == 0) @(posedge clk);
        pc   = q_pc.pop_front();
        inst = q_inst.pop_front();
        ex   = q_ex.pop_front();
        code = q_code.pop_front();
        bd   = q_bd.pop_front();
    endtask

    task automatic expect_word(input addr_t exp_pc);
        addr_t     pc;
        inst_t     inst;
        logic      ex;
        exc_code_t code;
        logic      bd;
        next_word(pc, inst, ex, code, bd);
        check(pc == exp_pc, $sformatf("pc %h, expected %h", pc, exp_pc));
        check(inst == mem_word(exp_pc), $sformatf("inst %h at pc %h", inst, exp_pc));
        check(!ex && code == EXC_NONE, $sformatf("exception %0d at pc %h", code, pc));
    endtask

    task automatic expect_run(input addr_t start, input int n);
        for (int i = 0; i < n; i++) begin
            expect_word(start + addr_t'(4 * i));
        end
    endtask

    // words already in flight may still arrive before the target
    task automatic reach(input addr_t target, output inst_t inst, output logic ex,
                         output exc_code_t code, output logic bd);
        addr_t pc;
        int    tries;
        tries = 0;
        pc    = ~target;
        while (pc != target && tries < 4) begin
            next_word(pc, inst, ex, code, bd);
            tries++;
        end
        check(pc == target, $sformatf("target %h not reached, last pc %h", target, pc));
    endtask

    task automatic reset_dut();
        @(posedge clk);
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        clear_words();
    endtask

    task automatic pulse_branch(input addr_t target, input logic stall, input logic mfc0,
                                input logic bd, input logic clear);
        @(posedge clk);
        if (clear) begin
            clear_words();
        end
        br_taken      <= 1'b1;
        br_target     <= target;
        br_stall      <= stall;
        mfc0_stall    <= mfc0;
        br_delay_slot <= bd;
        @(posedge clk);
        br_taken   <= 1'b0;
        br_stall   <= 1'b0;
        mfc0_stall <= 1'b0;
    endtask

    task automatic jump(input addr_t target, input logic exp_bd);
        inst_t     inst;
        logic      ex;
        exc_code_t code;
        logic      bd;
        pulse_branch(target, 1'b0, 1'b0, exp_bd, 1'b1);
        reach(target, inst, ex, code, bd);
        br_delay_slot <= 1'b0;
        check(inst == mem_word(target), $sformatf("inst %h at target %h", inst, target));
        check(!ex, $sformatf("exception at target %h", target));
        check(bd == exp_bd, $sformatf("fs_bd %b at target %h", bd, target));
    endtask

    task automatic pulse_kill(input logic is_eret, input addr_t ret_pc);
        @(posedge clk);
        clear_words();
        if (is_eret) begin
            eret <= 1'b1;
            epc  <= ret_pc;
        end else begin
            flush <= 1'b1;
        end
        @(posedge clk);
        flush <= 1'b0;
        eret  <= 1'b0;
    endtask

    task automatic sequential_fetch();
        reset_dut();
        for (int i = 0; i < 12; i++) begin
            expect_word(BOOT_PC + addr_t'(4 * i));
            // one refill per new line
            check(refill_count == i / 4 + 1,
                  $sformatf("refill count %0d after word %0d", refill_count, i));
        end
    endtask

    task automatic hit_and_replace();
        int n;
        jump(BOOT_PC, 1'b0);
        n = refill_log.size();
        expect_run(BOOT_PC + 4, 7);
        check(refill_log.size() == n, "refill on a cached line");
        jump(LINE_A, 1'b0);
        expect_run(LINE_A + 4, 3);
        jump(LINE_B, 1'b0);
        expect_run(LINE_B + 4, 3);
        // third line in the set evicts A
        jump(LINE_C, 1'b0);
        expect_run(LINE_C + 4, 3);
        jump(LINE_B, 1'b0);
        check(refills_of(LINE_B) == 1, $sformatf("line B refilled %0d times",
              refills_of(LINE_B)));
        jump(LINE_A, 1'b0);
        check(refills_of(LINE_A) == 2, $sformatf("line A refilled %0d times",
              refills_of(LINE_A)));
    endtask

    task automatic branch_redirect();
        jump(BR_TARGET, 1'b1);
        expect_run(BR_TARGET + 4, 4);
        // stalled branches leave the sequence alone
        pulse_branch(STALL_TGT, 1'b1, 1'b0, 1'b0, 1'b0);
        expect_run(BR_TARGET + 20, 4);
        pulse_branch(STALL_TGT, 1'b0, 1'b1, 1'b0, 1'b0);
        expect_run(BR_TARGET + 36, 4);
    endtask

    task automatic misaligned_target();
        inst_t     inst;
        logic      ex;
        exc_code_t code;
        logic      bd;
        pulse_branch(MIS_TGT, 1'b0, 1'b0, 1'b0, 1'b1);
        reach(MIS_TGT, inst, ex, code, bd);
        check(ex && code == EXC_ADEL, $sformatf("ex %b code %0d on misaligned pc", ex, code));
        check(inst == '0, $sformatf("inst %h on misaligned pc", inst));
        repeat (20) @(posedge clk);
        check(refills_of({MIS_TGT[31:4], 4'h0}) == 0, "refill for a misaligned pc");
    endtask

    task automatic flush_and_eret();
        // flush lands while the miss on the next line is outstanding
        jump(LINE_END, 1'b0);
        pulse_kill(1'b0, '0);
        expect_run(EXC_VECTOR, 4);
        pulse_kill(1'b1, EPC_ADDR);
        expect_run(EPC_ADDR, 4);
    endtask

    task automatic decode_backpressure();
        reset_dut();
        bp_en <= 1'b1;
        expect_run(BOOT_PC, 24);
        bp_en          <= 1'b0;
        decode_allowin <= 1'b1;
    endtask

    initial begin
        void'($urandom(32'hafb8_fa8e));
        reset          = 1'b1;
        decode_allowin = 1'b1;
        br_taken       = 1'b0;
        br_stall       = 1'b0;
        br_target      = '0;
        br_delay_slot  = 1'b0;
        flush          = 1'b0;
        eret           = 1'b0;
        epc            = '0;
        mfc0_stall     = 1'b0;
        bp_en          = 1'b0;
        mem_req_prev   = 1'b0;
        error_count    = 0;
        check_count    = 0;
        sequential_fetch();
        hit_and_replace();
        branch_redirect();
        misaligned_target();
        flush_and_eret();
        decode_backpressure();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TEST_CYCLES * MARGIN * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES * MARGIN);
        $display("checks %0d, errors %0d", check_count, error_count);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  logic              clk,
    input  logic              reset,
    input  logic              mem_req,
    input  fetch_pkg::addr_t  mem_addr,
    output logic              mem_ack,
    output fetch_pkg::line_t  mem_line,
    output int                refill_count
);
    import fetch_pkg::*;

    // cycles spent with req high before ack comes up
    localparam int ACK_DELAY = 3;

    int delay_q;

    // word at an aligned address is the address xor 5a5a0000
    function automatic line_t line_at(input addr_t base);
        line_t l;
        for (int k = 0; k < 4; k++) begin
            l[32*k +: 32] = (base + addr_t'(4 * k)) ^ 32'h5a5a_0000;
        end
        return l;
    endfunction

    // four phase responder
    // ack rises after a delay, falls once req has dropped
    always @(posedge clk) begin
        if (reset) begin
            mem_ack      <= 1'b0;
            mem_line     <= '0;
            delay_q      <= 0;
            refill_count <= 0;
        end else if (!mem_ack) begin
            if (mem_req) begin
                if (delay_q == ACK_DELAY - 1) begin
                    mem_ack      <= 1'b1;
                    mem_line     <= line_at(mem_addr);
                    refill_count <= refill_count + 1;
                    delay_q      <= 0;
                end else begin
                    delay_q <= delay_q + 1;
                end
            end
        end else if (!mem_req) begin
            mem_ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  decode_allowin,
    input  logic                  br_taken,
    input  logic                  br_stall,
    input  fetch_pkg::addr_t      br_target,
    input  logic                  br_delay_slot,
    input  logic                  flush,
    input  logic                  eret,
    input  fetch_pkg::addr_t      epc,
    input  logic                  mfc0_stall,
    output logic                  fs_valid,
    output fetch_pkg::addr_t      fs_pc,
    output fetch_pkg::inst_t      fs_inst,
    output logic                  fs_ex,
    output fetch_pkg::exc_code_t  fs_exc_code,
    output logic                  fs_bd,
    output logic                  mem_req,
    output fetch_pkg::addr_t      mem_addr,
    input  logic                  mem_ack,
    input  fetch_pkg::line_t      mem_line
);
    import fetch_pkg::*;

    // request side between fetch and cache
    logic    inst_req;
    tag_t    inst_tag;
    index_t  inst_index;
    offset_t inst_offset;
    logic    inst_addr_ok;
    logic    inst_data_ok;
    inst_t   inst_rdata;

    fetch_stage fetch_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .decode_allowin (decode_allowin),
        .br_taken       (br_taken),
        .br_stall       (br_stall),
        .br_target      (br_target),
        .br_delay_slot  (br_delay_slot),
        .flush          (flush),
        .eret           (eret),
        .epc            (epc),
        .mfc0_stall     (mfc0_stall),
        .inst_addr_ok   (inst_addr_ok),
        .inst_data_ok   (inst_data_ok),
        .inst_rdata     (inst_rdata),
        .fs_valid       (fs_valid),
        .fs_pc          (fs_pc),
        .fs_inst        (fs_inst),
        .fs_ex          (fs_ex),
        .fs_exc_code    (fs_exc_code),
        .fs_bd          (fs_bd),
        .inst_req       (inst_req),
        .inst_tag       (inst_tag),
        .inst_index     (inst_index),
        .inst_offset    (inst_offset)
    );

    // read only cache with its own refill port
    icache_ctrl icache_ctrl_inst (
        .clk          (clk),
        .reset        (reset),
        .inst_req     (inst_req),
        .inst_tag     (inst_tag),
        .inst_index   (inst_index),
        .inst_offset  (inst_offset),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_ack      (mem_ack),
        .mem_line     (mem_line)
    );

endmodule

`default_nettype wire

/* source/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                inst_req,
    input  fetch_pkg::tag_t     inst_tag,
    input  fetch_pkg::index_t   inst_index,
    input  fetch_pkg::offset_t  inst_offset,
    output logic                inst_addr_ok,
    output logic                inst_data_ok,
    output fetch_pkg::inst_t    inst_rdata,
    output logic                mem_req,
    output fetch_pkg::addr_t    mem_addr,
    input  logic                mem_ack,
    input  fetch_pkg::line_t    mem_line
);
    import fetch_pkg::*;

    refill_state_e       state_q;
    refill_state_e       state_d;
    tag_t                req_tag_q;
    index_t              req_index_q;
    offset_t             req_offset_q;
    way_t                victim_q;
    line_t               fill_line_q;
    logic [NUM_SETS-1:0] lru_q;
    logic [NUM_WAYS-1:0] way_hit;
    logic [NUM_WAYS-1:0] way_we;
    line_t               way_line [NUM_WAYS];
    logic                hit_any;
    way_t                hit_way;
    line_t               hit_line;
    logic                accept;

    // new requests only while idle
    assign inst_addr_ok = (state_q == ST_IDLE);
    assign accept       = inst_req & inst_addr_ok;

    // latch the request
    always_ff @(posedge clk) begin
        if (accept) begin
            req_tag_q    <= inst_tag;
            req_index_q  <= inst_index;
            req_offset_q <= inst_offset;
        end
    end

    // all ways see the registered index and tag
    // only the victim way is written during fill
    generate
        for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
            assign way_we[w] = (state_q == ST_FILL) && (victim_q == way_t'(w));

            icache_way way_inst (
                .clk        (clk),
                .reset      (reset),
                .index      (req_index_q),
                .tag        (req_tag_q),
                .write_en   (way_we[w]),
                .write_line (fill_line_q),
                .hit        (way_hit[w]),
                .line       (way_line[w])
            );
        end
    endgenerate

    // hit way select
    // at most one way matches a given tag
    always_comb begin
        hit_way  = '0;
        hit_line = way_line[0];
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (way_hit[i]) begin
                hit_way  = way_t'(i);
                hit_line = way_line[i];
            end
        end
    end

    assign hit_any = |way_hit;

    // word out of the line by offset bits 3..2
    // after a refill the lookup reads back the line just captured
    assign inst_rdata   = hit_line[req_offset_q[3:2]*32 +: 32];
    assign inst_data_ok = (state_q == ST_LOOKUP) && hit_any;

    // one lru bit per set, set means way 1 is next to go
    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (inst_data_ok) begin
            lru_q[req_index_q] <= (hit_way == '0);
        end
    end

    // victim picked on the miss
    always_ff @(posedge clk) begin
        if ((state_q == ST_LOOKUP) && !hit_any) begin
            victim_q <= way_t'(lru_q[req_index_q]);
        end
    end

    // line captured on ack
    always_ff @(posedge clk) begin
        if ((state_q == ST_MEM_REQ) && mem_ack) begin
            fill_line_q <= mem_line;
        end
    end

    // four phase refill
    // req up, ack up, req down, ack down, then fill
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit_any) begin
                    state_d = ST_IDLE;
                end else begin
                    state_d = ST_MEM_REQ;
                end
            end
            ST_MEM_REQ: begin
                if (mem_ack) begin
                    state_d = ST_MEM_WAIT_DROP;
                end
            end
            ST_MEM_WAIT_DROP: begin
                // memory must release ack before the next transfer
                if (!mem_ack) begin
                    state_d = ST_FILL;
                end
            end
            ST_FILL: begin
                // relookup hits the freshly written way
                state_d = ST_LOOKUP;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // address held by the request registers for the whole transfer
    assign mem_req  = (state_q == ST_MEM_REQ);
    assign mem_addr = {req_tag_q, req_index_q, 4'b0000};

endmodule

`default_nettype wire

/* source/icache_way.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_way (
    input  logic                clk,
    input  logic                reset,
    input  fetch_pkg::index_t   index,
    input  fetch_pkg::tag_t     tag,
    input  logic                write_en,
    input  fetch_pkg::line_t    write_line,
    output logic                hit,
    output fetch_pkg::line_t    line
);
    import fetch_pkg::*;

    logic [NUM_SETS-1:0] valid_q;
    tag_t                tag_mem  [NUM_SETS];
    line_t               line_mem [NUM_SETS];

    // valid bits are the only state cleared at reset
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (write_en) begin
            valid_q[index] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (write_en) begin
            tag_mem[index]  <= tag;
            line_mem[index] <= write_line;
        end
    end

    // combinational read of the addressed set
    assign hit  = valid_q[index] && (tag_mem[index] == tag);
    assign line = line_mem[index];

endmodule

`default_nettype wire

/* source/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  decode_allowin,
    input  logic                  br_taken,
    input  logic                  br_stall,
    input  fetch_pkg::addr_t      br_target,
    input  logic                  br_delay_slot,
    input  logic                  flush,
    input  logic                  eret,
    input  fetch_pkg::addr_t      epc,
    input  logic                  mfc0_stall,
    input  logic                  inst_addr_ok,
    input  logic                  inst_data_ok,
    input  fetch_pkg::inst_t      inst_rdata,
    output logic                  fs_valid,
    output fetch_pkg::addr_t      fs_pc,
    output fetch_pkg::inst_t      fs_inst,
    output logic                  fs_ex,
    output fetch_pkg::exc_code_t  fs_exc_code,
    output logic                  fs_bd,
    output logic                  inst_req,
    output fetch_pkg::tag_t       inst_tag,
    output fetch_pkg::index_t     inst_index,
    output fetch_pkg::offset_t    inst_offset
);
    import fetch_pkg::*;

    logic  run_q;
    logic  busy_q;
    logic  flush_q;
    logic  drop_q;
    logic  req_bd_q;
    addr_t req_pc_q;
    addr_t npc_buf_q;
    addr_t next_pc;
    logic  kill;
    logic  br_redirect;
    logic  next_misaligned;
    logic  out_free;
    logic  slot_open;
    logic  accept;
    logic  take_exc;
    logic  take_word;

    // eret and flush both throw away whatever is in flight
    assign kill = flush | eret;

    // branch only redirects once its operands and cp0 reads are settled
    assign br_redirect = br_taken & ~br_stall & ~mfc0_stall;

    // next pc priority
    always_comb begin
        if (eret) begin
            next_pc = epc;
        end else if (flush | flush_q) begin
            next_pc = EXC_VECTOR;
        end else if (br_redirect) begin
            next_pc = br_target;
        end else begin
            next_pc = npc_buf_q;
        end
    end

    assign next_misaligned = |next_pc[1:0];

    // output slot free when empty, draining now, or being flushed
    assign out_free  = ~fs_valid | decode_allowin | kill;
    // one request in flight at most
    assign slot_open = run_q & ~busy_q & out_free;

    // misaligned pc never goes to the cache
    assign inst_req = slot_open & ~next_misaligned;
    assign accept   = inst_req & inst_addr_ok;
    assign take_exc = slot_open & next_misaligned;

    // returned word is dropped if a flush or eret hit while it was in flight
    assign take_word = inst_data_ok & busy_q & ~drop_q & ~kill;

    assign {inst_tag, inst_index, inst_offset} = next_pc;

    // holds off the first request until reset has been released
    always_ff @(posedge clk) begin
        if (reset) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end else if (inst_data_ok) begin
            busy_q <= 1'b0;
        end
    end

    // flush seen while busy keeps steering next_pc to the vector
    // an eret overrides it since epc is the newer target
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_q <= 1'b0;
        end else if (inst_data_ok | eret) begin
            flush_q <= 1'b0;
        end else if (flush & busy_q) begin
            flush_q <= 1'b1;
        end
    end

    // discard marker for the outstanding word
    always_ff @(posedge clk) begin
        if (reset) begin
            drop_q <= 1'b0;
        end else if (inst_data_ok) begin
            drop_q <= 1'b0;
        end else if (kill & busy_q) begin
            drop_q <= 1'b1;
        end
    end

    // next pc buffer
    // steps past whatever was taken, otherwise tracks redirects
    always_ff @(posedge clk) begin
        if (reset) begin
            npc_buf_q <= RESET_PC + 32'd4;
        end else if (accept | take_exc) begin
            npc_buf_q <= next_pc + 32'd4;
        end else begin
            npc_buf_q <= next_pc;
        end
    end

    // pc and delay slot flag of the request in flight
    always_ff @(posedge clk) begin
        if (accept) begin
            req_pc_q <= next_pc;
            req_bd_q <= br_delay_slot;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (take_word | take_exc) begin
            fs_valid <= 1'b1;
        end else if (kill | decode_allowin) begin
            fs_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc <= RESET_PC;
        end else if (take_word) begin
            fs_pc <= req_pc_q;
        end else if (take_exc) begin
            fs_pc <= next_pc;
        end
    end

    // zero instruction on misaligned fetch or flush
    always_ff @(posedge clk) begin
        if (take_word) begin
            fs_inst <= inst_rdata;
            fs_bd   <= req_bd_q;
        end else if (take_exc) begin
            fs_inst <= '0;
            fs_bd   <= br_delay_slot;
        end else if (kill) begin
            fs_inst <= '0;
        end
    end

    // adel tag follows the pc held for decode
    assign fs_ex       = |fs_pc[1:0];
    assign fs_exc_code = fs_ex ? EXC_ADEL : EXC_NONE;

endmodule

`default_nettype wire

/* source/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // byte address and instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // cp0 cause code width
    typedef logic [4:0] exc_code_t;

    // address split seen by the cache
    // tag is bits 31..12, index 11..4, offset 3..0
    typedef logic [19:0] tag_t;
    typedef logic [7:0]  index_t;
    typedef logic [3:0]  offset_t;

    // four words per line, word k at bits 32k+31 down to 32k
    typedef logic [127:0] line_t;

    // pc register value out of reset, one word before the boot vector
    localparam addr_t RESET_PC = 32'hbfbf_fffc;

    // general exception entry in kseg1
    localparam addr_t EXC_VECTOR = 32'hbfc0_0380;

    // address error on load or fetch
    localparam exc_code_t EXC_ADEL = 5'd4;
    // all ones marks no exception
    localparam exc_code_t EXC_NONE = 5'd31;

    // cache geometry
    localparam int NUM_WAYS = 2;
    localparam int NUM_SETS = 256;
    localparam int WAY_W    = $clog2(NUM_WAYS);

    typedef logic [WAY_W-1:0] way_t;

    // refill fsm of the cache controller
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MEM_REQ,
        ST_MEM_WAIT_DROP,
        ST_FILL
    } refill_state_e;

endpackage

`default_nettype wire
